//--- Bender.yml
package:
  name: rgbw_controller

sources:
  - include_dirs:
      - source
    files:
      - source/led_cfg_pkg.sv
      - source/mul_pkg.sv
      - source/spi_register_file.sv
      - source/mul_arbiter.sv
      - source/intensity_scaler.sv
      - source/hue_wheel.sv
      - source/pwm_generator.sv
      - source/rgbw_controller.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/clock_gen.sv
      - tests/rgbw_chk.sv
      - tests/tb_rgbw_controller.sv

//--- build.f
+incdir+source
source/led_cfg_pkg.sv
source/mul_pkg.sv
source/spi_register_file.sv
source/mul_arbiter.sv
source/intensity_scaler.sv
source/hue_wheel.sv
source/pwm_generator.sv
source/rgbw_controller.sv
tests/clock_gen.sv
tests/rgbw_chk.sv
tests/tb_rgbw_controller.sv

//--- source/hue_wheel.sv
`timescale 1ns/10ps
`include "led_macros.svh"

module hue_wheel
    import mul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`LED_DW-1:0]   hue,
    input  logic [`LED_DW-1:0]   lint,
    input  logic                 grant,
    input  logic                 valid,
    input  logic [2*`LED_DW-1:0] product,
    output logic                 req,
    output logic [`LED_DW-1:0]   a,
    output logic [`LED_DW-1:0]   b,
    output mul_req_t             tag,
    output logic [`LED_DW-1:0]   red_duty,
    output logic [`LED_DW-1:0]   green_duty,
    output logic [`LED_DW-1:0]   blue_duty
);

    typedef enum logic {ST_ISSUE, ST_WAIT} eng_state_t;

    localparam logic [`LED_DW-1:0] SECTOR1 = `HUE_SECTOR;
    localparam logic [`LED_DW-1:0] SECTOR2 = 2 * `HUE_SECTOR;

    eng_state_t         state;
    logic [1:0]         chan;
    logic [`LED_DW-1:0] pos;
    logic [`LED_DW-1:0] ramp_up;
    logic [`LED_DW-1:0] ramp_dn;
    logic [`LED_DW-1:0] raw_r;
    logic [`LED_DW-1:0] raw_g;
    logic [`LED_DW-1:0] raw_b;

    // position inside the sector, ramps are 3*pos and 255-3*pos
    always_comb
    begin
        if (hue < SECTOR1)
            pos = hue;
        else if (hue < SECTOR2)
            pos = hue - SECTOR1;
        else
            pos = hue - SECTOR2;
        ramp_up = {pos[`LED_DW-2:0], 1'b0} + pos;
        ramp_dn = {`LED_DW{1'b1}} - ramp_up;
        if (hue < SECTOR1)
        begin
            raw_r = ramp_dn;
            raw_g = ramp_up;
            raw_b = '0;
        end
        else if (hue < SECTOR2)
        begin
            raw_r = '0;
            raw_g = ramp_dn;
            raw_b = ramp_up;
        end
        else
        begin
            raw_r = ramp_up;
            raw_g = '0;
            raw_b = ramp_dn;
        end
    end

    assign tag = REQ_WHEEL;
    assign req = (state == ST_ISSUE);
    assign a   = (chan == 2'd0) ? raw_r : (chan == 2'd1) ? raw_g : raw_b;
    assign b   = lint;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state      <= ST_ISSUE;
            chan       <= '0;
            red_duty   <= '0;
            green_duty <= '0;
            blue_duty  <= '0;
        end
        else if (state == ST_ISSUE)
        begin
            if (grant)
                state <= ST_WAIT;
        end
        else if (valid)
        begin
            case (chan)
                2'd0:    red_duty   <= product[2*`LED_DW-1:`LED_DW];
                2'd1:    green_duty <= product[2*`LED_DW-1:`LED_DW];
                default: blue_duty  <= product[2*`LED_DW-1:`LED_DW];
            endcase
            chan  <= (chan == 2'd2) ? 2'd0 : chan + 2'd1;
            state <= ST_ISSUE;
        end
    end

endmodule

//--- source/intensity_scaler.sv
`timescale 1ns/10ps
`include "led_macros.svh"

module intensity_scaler
    import mul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`LED_DW-1:0]   lint,
    input  logic [`LED_DW-1:0]   red,
    input  logic [`LED_DW-1:0]   green,
    input  logic [`LED_DW-1:0]   blue,
    input  logic [`LED_DW-1:0]   white,
    input  logic                 grant,
    input  logic                 valid,
    input  logic [2*`LED_DW-1:0] product,
    output logic                 req,
    output logic [`LED_DW-1:0]   a,
    output logic [`LED_DW-1:0]   b,
    output mul_req_t             tag,
    output logic [`LED_DW-1:0]   red_duty,
    output logic [`LED_DW-1:0]   green_duty,
    output logic [`LED_DW-1:0]   blue_duty,
    output logic [`LED_DW-1:0]   white_duty
);

    typedef enum logic {ST_ISSUE, ST_WAIT} eng_state_t;

    eng_state_t state;
    logic [1:0] chan;

    assign tag = REQ_SCALER;
    // request only while the credit is ours
    assign req = (state == ST_ISSUE);
    assign b   = lint;

    always_comb
    begin
        case (chan)
            2'd0:    a = red;
            2'd1:    a = green;
            2'd2:    a = blue;
            default: a = white;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state      <= ST_ISSUE;
            chan       <= '0;
            red_duty   <= '0;
            green_duty <= '0;
            blue_duty  <= '0;
            white_duty <= '0;
        end
        else if (state == ST_ISSUE)
        begin
            if (grant)
                state <= ST_WAIT;
        end
        else if (valid)
        begin
            case (chan)
                2'd0:    red_duty   <= product[2*`LED_DW-1:`LED_DW];
                2'd1:    green_duty <= product[2*`LED_DW-1:`LED_DW];
                2'd2:    blue_duty  <= product[2*`LED_DW-1:`LED_DW];
                default: white_duty <= product[2*`LED_DW-1:`LED_DW];
            endcase
            // four channels, counter wraps by itself
            chan  <= chan + 2'd1;
            state <= ST_ISSUE;
        end
    end

endmodule

//--- source/led_cfg_pkg.sv
package led_cfg_pkg;

    // operating mode register encoding
    // undefined values are treated as off
    typedef enum logic [7:0] {
        MODE_OFF    = 8'd0,
        MODE_STATIC = 8'd1,
        MODE_WHEEL  = 8'd2
    } led_mode_t;

    // register map seen by the spi host
    typedef enum logic [7:0] {
        ADDR_MODE  = 8'd0,
        ADDR_LINT  = 8'd1,
        ADDR_RED   = 8'd2,
        ADDR_GREEN = 8'd3,
        ADDR_BLUE  = 8'd4,
        ADDR_WHITE = 8'd5,
        ADDR_HUE   = 8'd6
    } reg_addr_t;

endpackage

//--- source/led_macros.svh
`ifndef LED_MACROS_SVH
`define LED_MACROS_SVH

// color and register data width
`define LED_DW 8

// clk cycles per pwm counter tick
`define PWM_PRESCALE 2

// engines sharing the multiplier
`define MUL_REQS 2

// hue positions per color sector
`define HUE_SECTOR 85

// grant to result, in clk cycles
`define MUL_LATENCY 2

`endif

//--- source/mul_arbiter.sv
`timescale 1ns/10ps
`include "led_macros.svh"

module mul_arbiter
    import mul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_scaler,
    input  logic [`LED_DW-1:0]   a_scaler,
    input  logic [`LED_DW-1:0]   b_scaler,
    input  mul_req_t             tag_scaler,
    input  logic                 req_wheel,
    input  logic [`LED_DW-1:0]   a_wheel,
    input  logic [`LED_DW-1:0]   b_wheel,
    input  mul_req_t             tag_wheel,
    output logic                 grant_scaler,
    output logic                 grant_wheel,
    output logic                 valid_scaler,
    output logic                 valid_wheel,
    output logic [2*`LED_DW-1:0] product
);

    logic [`MUL_REQS-1:0]    credit;
    arb_state_t              last_grant;
    logic                    ok_scaler;
    logic                    ok_wheel;
    logic [`LED_DW-1:0]      op_a;
    logic [`LED_DW-1:0]      op_b;
    logic [2*`LED_DW-1:0]    prod_q;
    logic [`MUL_LATENCY-1:0] vld_pipe;
    mul_req_t                tag_pipe [`MUL_LATENCY];

    assign ok_scaler = req_scaler && credit[REQ_SCALER];
    assign ok_wheel  = req_wheel && credit[REQ_WHEEL];

    // on a tie, the engine not served last wins
    assign grant_scaler = ok_scaler && (!ok_wheel || last_grant == LAST_WHEEL);
    assign grant_wheel  = ok_wheel && !grant_scaler;

    assign valid_scaler = vld_pipe[`MUL_LATENCY-1] && tag_pipe[`MUL_LATENCY-1] == REQ_SCALER;
    assign valid_wheel  = vld_pipe[`MUL_LATENCY-1] && tag_pipe[`MUL_LATENCY-1] == REQ_WHEEL;
    assign product      = prod_q;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            credit     <= '1;
            last_grant <= LAST_WHEEL;
            vld_pipe   <= '0;
        end
        else
        begin
            vld_pipe <= {vld_pipe[`MUL_LATENCY-2:0], grant_scaler || grant_wheel};
            if (grant_scaler)
                last_grant <= LAST_SCALER;
            else if (grant_wheel)
                last_grant <= LAST_WHEEL;
            // grant spends the credit, result brings it back
            if (grant_scaler)
                credit[REQ_SCALER] <= 1'b0;
            else if (valid_scaler)
                credit[REQ_SCALER] <= 1'b1;
            if (grant_wheel)
                credit[REQ_WHEEL] <= 1'b0;
            else if (valid_wheel)
                credit[REQ_WHEEL] <= 1'b1;
        end
    end

    // stage 1 latches operands, stage 2 holds the product
    always_ff @(posedge clk)
    begin
        op_a        <= grant_scaler ? a_scaler : a_wheel;
        op_b        <= grant_scaler ? b_scaler : b_wheel;
        tag_pipe[0] <= grant_scaler ? tag_scaler : tag_wheel;
        for (int i = 1; i < `MUL_LATENCY; i++)
            tag_pipe[i] <= tag_pipe[i-1];
        prod_q <= op_a * op_b;
    end

endmodule

//--- source/mul_pkg.sv
package mul_pkg;

    // requester tag, travels with the product
    typedef enum logic [0:0] {
        REQ_SCALER = 1'b0,
        REQ_WHEEL  = 1'b1
    } mul_req_t;

    // which engine got the last grant
    typedef enum logic {
        LAST_SCALER = 1'b0,
        LAST_WHEEL  = 1'b1
    } arb_state_t;

endpackage

//--- source/pwm_generator.sv
`timescale 1ns/10ps
`include "led_macros.svh"

module pwm_generator (
    input  logic               clk,
    input  logic               reset,
    input  logic [`LED_DW-1:0] duty_r,
    input  logic [`LED_DW-1:0] duty_g,
    input  logic [`LED_DW-1:0] duty_b,
    input  logic [`LED_DW-1:0] duty_w,
    output logic               pin_r,
    output logic               pin_g,
    output logic               pin_b,
    output logic               pin_w
);

    logic [7:0]         presc;
    logic               tick;
    logic [`LED_DW-1:0] cnt;
    logic [`LED_DW-1:0] duty_r_q;
    logic [`LED_DW-1:0] duty_g_q;
    logic [`LED_DW-1:0] duty_b_q;
    logic [`LED_DW-1:0] duty_w_q;

    assign tick = (presc == 8'(`PWM_PRESCALE - 1));

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            presc    <= '0;
            cnt      <= '0;
            duty_r_q <= '0;
            duty_g_q <= '0;
            duty_b_q <= '0;
            duty_w_q <= '0;
            pin_r    <= 1'b0;
            pin_g    <= 1'b0;
            pin_b    <= 1'b0;
            pin_w    <= 1'b0;
        end
        else
        begin
            presc <= tick ? 8'd0 : presc + 8'd1;
            if (tick)
                cnt <= cnt + 1'b1;
            // new duties only at the wrap, one duty per period
            if (tick && cnt == {`LED_DW{1'b1}})
            begin
                duty_r_q <= duty_r;
                duty_g_q <= duty_g;
                duty_b_q <= duty_b;
                duty_w_q <= duty_w;
            end
            pin_r <= (cnt < duty_r_q);
            pin_g <= (cnt < duty_g_q);
            pin_b <= (cnt < duty_b_q);
            pin_w <= (cnt < duty_w_q);
        end
    end

endmodule

//--- source/rgbw_controller.sv
`timescale 1ns/10ps
`include "led_macros.svh"

module rgbw_controller
    import led_cfg_pkg::*;
    import mul_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic sck,
    input  logic cs,
    input  logic mosi,
    output logic pin_r,
    output logic pin_g,
    output logic pin_b,
    output logic pin_w
);

    led_mode_t            mode;
    logic [`LED_DW-1:0]   lint;
    logic [`LED_DW-1:0]   red;
    logic [`LED_DW-1:0]   green;
    logic [`LED_DW-1:0]   blue;
    logic [`LED_DW-1:0]   white;
    logic [`LED_DW-1:0]   hue;
    logic                 req_scaler;
    logic                 req_wheel;
    logic [`LED_DW-1:0]   a_scaler;
    logic [`LED_DW-1:0]   b_scaler;
    logic [`LED_DW-1:0]   a_wheel;
    logic [`LED_DW-1:0]   b_wheel;
    mul_req_t             tag_scaler;
    mul_req_t             tag_wheel;
    logic                 grant_scaler;
    logic                 grant_wheel;
    logic                 valid_scaler;
    logic                 valid_wheel;
    logic [2*`LED_DW-1:0] product;
    logic [`LED_DW-1:0]   s_red;
    logic [`LED_DW-1:0]   s_green;
    logic [`LED_DW-1:0]   s_blue;
    logic [`LED_DW-1:0]   s_white;
    logic [`LED_DW-1:0]   w_red;
    logic [`LED_DW-1:0]   w_green;
    logic [`LED_DW-1:0]   w_blue;
    logic [`LED_DW-1:0]   duty_r;
    logic [`LED_DW-1:0]   duty_g;
    logic [`LED_DW-1:0]   duty_b;
    logic [`LED_DW-1:0]   duty_w;

    spi_register_file regs_i (
        .clk   (clk),
        .reset (reset),
        .sck   (sck),
        .cs    (cs),
        .mosi  (mosi),
        .mode  (mode),
        .lint  (lint),
        .red   (red),
        .green (green),
        .blue  (blue),
        .white (white),
        .hue   (hue)
    );

    mul_arbiter arb_i (
        .clk          (clk),
        .reset        (reset),
        .req_scaler   (req_scaler),
        .a_scaler     (a_scaler),
        .b_scaler     (b_scaler),
        .tag_scaler   (tag_scaler),
        .req_wheel    (req_wheel),
        .a_wheel      (a_wheel),
        .b_wheel      (b_wheel),
        .tag_wheel    (tag_wheel),
        .grant_scaler (grant_scaler),
        .grant_wheel  (grant_wheel),
        .valid_scaler (valid_scaler),
        .valid_wheel  (valid_wheel),
        .product      (product)
    );

    intensity_scaler scaler_i (
        .clk        (clk),
        .reset      (reset),
        .lint       (lint),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .white      (white),
        .grant      (grant_scaler),
        .valid      (valid_scaler),
        .product    (product),
        .req        (req_scaler),
        .a          (a_scaler),
        .b          (b_scaler),
        .tag        (tag_scaler),
        .red_duty   (s_red),
        .green_duty (s_green),
        .blue_duty  (s_blue),
        .white_duty (s_white)
    );

    hue_wheel wheel_i (
        .clk        (clk),
        .reset      (reset),
        .hue        (hue),
        .lint       (lint),
        .grant      (grant_wheel),
        .valid      (valid_wheel),
        .product    (product),
        .req        (req_wheel),
        .a          (a_wheel),
        .b          (b_wheel),
        .tag        (tag_wheel),
        .red_duty   (w_red),
        .green_duty (w_green),
        .blue_duty  (w_blue)
    );

    // color source by mode, white always from the scaler
    always_comb
    begin
        case (mode)
            MODE_STATIC:
            begin
                duty_r = s_red;
                duty_g = s_green;
                duty_b = s_blue;
                duty_w = s_white;
            end
            MODE_WHEEL:
            begin
                duty_r = w_red;
                duty_g = w_green;
                duty_b = w_blue;
                duty_w = s_white;
            end
            default:
            begin
                duty_r = '0;
                duty_g = '0;
                duty_b = '0;
                duty_w = '0;
            end
        endcase
    end

    pwm_generator pwm_i (
        .clk    (clk),
        .reset  (reset),
        .duty_r (duty_r),
        .duty_g (duty_g),
        .duty_b (duty_b),
        .duty_w (duty_w),
        .pin_r  (pin_r),
        .pin_g  (pin_g),
        .pin_b  (pin_b),
        .pin_w  (pin_w)
    );

endmodule

//--- source/spi_register_file.sv
`timescale 1ns/10ps
`include "led_macros.svh"

module spi_register_file
    import led_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              sck,
    input  logic              cs,
    input  logic              mosi,
    output led_mode_t         mode,
    output logic [`LED_DW-1:0] lint,
    output logic [`LED_DW-1:0] red,
    output logic [`LED_DW-1:0] green,
    output logic [`LED_DW-1:0] blue,
    output logic [`LED_DW-1:0] white,
    output logic [`LED_DW-1:0] hue
);

    logic [2:0]            sck_sync;
    logic [1:0]            mosi_sync;
    logic [1:0]            cs_sync;
    logic                  sck_rise;
    logic [2*`LED_DW-2:0]  shift;
    logic [4:0]            bit_cnt;
    logic [`LED_DW-1:0]    wr_data;
    reg_addr_t             wr_addr;

    // third sck flop only for edge detection
    assign sck_rise = sck_sync[1] && !sck_sync[2];

    // address byte sits in the upper bits once 15 bits are in
    assign wr_addr = reg_addr_t'(shift[2*`LED_DW-2:`LED_DW-1]);
    assign wr_data = {shift[`LED_DW-2:0], mosi_sync[1]};

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            sck_sync  <= '0;
            mosi_sync <= '0;
            cs_sync   <= '1;
        end
        else
        begin
            sck_sync  <= {sck_sync[1:0], sck};
            mosi_sync <= {mosi_sync[0], mosi};
            cs_sync   <= {cs_sync[0], cs};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            bit_cnt <= '0;
            shift   <= '0;
            mode    <= MODE_OFF;
            lint    <= '0;
            red     <= '0;
            green   <= '0;
            blue    <= '0;
            white   <= '0;
            hue     <= '0;
        end
        else if (cs_sync[1])
        begin
            // deselected, drop any partial transfer
            bit_cnt <= '0;
        end
        else if (sck_rise)
        begin
            shift <= {shift[2*`LED_DW-3:0], mosi_sync[1]};
            if (bit_cnt == 5'd15)
            begin
                bit_cnt <= '0;
                case (wr_addr)
                    ADDR_MODE:  mode  <= led_mode_t'(wr_data);
                    ADDR_LINT:  lint  <= wr_data;
                    ADDR_RED:   red   <= wr_data;
                    ADDR_GREEN: green <= wr_data;
                    ADDR_BLUE:  blue  <= wr_data;
                    ADDR_WHITE: white <= wr_data;
                    ADDR_HUE:   hue   <= wr_data;
                    default:    ;
                endcase
            end
            else
            begin
                bit_cnt <= bit_cnt + 5'd1;
            end
        end
    end

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // active low, held for two rising edges
    initial
    begin
        reset = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

endmodule

//--- tests/rgbw_chk.sv
`timescale 1ns/10ps

module rgbw_chk
    import led_cfg_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input led_mode_t mode,
    input logic      grant_scaler,
    input logic      grant_wheel,
    input logic      valid_scaler,
    input logic      valid_wheel,
    input logic      pin_r,
    input logic      pin_g,
    input logic      pin_b,
    input logic      pin_w
);

    // two pwm periods plus register and latch margin
    localparam int OFF_SETTLE = 1040;

    int unsigned fail_count = 0;
    int          off_cycles;
    logic        colour_mode;
    logic        scaler_busy;
    logic        wheel_busy;

    assign colour_mode = (mode == MODE_STATIC) || (mode == MODE_WHEEL);

    // cycles spent in an off mode since the last colour mode
    always_ff @(posedge clk)
    begin
        if (!reset)
            off_cycles <= 0;
        else if (colour_mode)
            off_cycles <= 0;
        else if (off_cycles < OFF_SETTLE)
            off_cycles <= off_cycles + 1;
    end

    // product in flight, from grant until its result valid
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            scaler_busy <= 1'b0;
            wheel_busy  <= 1'b0;
        end
        else
        begin
            if (grant_scaler)
                scaler_busy <= 1'b1;
            else if (valid_scaler)
                scaler_busy <= 1'b0;
            if (grant_wheel)
                wheel_busy <= 1'b1;
            else if (valid_wheel)
                wheel_busy <= 1'b0;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!reset)
        !(grant_scaler && grant_wheel))
    else
    begin
        $error("scaler and wheel granted in the same cycle");
        fail_count++;
    end

    a_scaler_latency: assert property (@(posedge clk) disable iff (!reset)
        grant_scaler |-> ##2 valid_scaler)
    else
    begin
        $error("scaler result valid not two cycles after its grant");
        fail_count++;
    end

    a_wheel_latency: assert property (@(posedge clk) disable iff (!reset)
        grant_wheel |-> ##2 valid_wheel)
    else
    begin
        $error("wheel result valid not two cycles after its grant");
        fail_count++;
    end

    a_scaler_credit: assert property (@(posedge clk) disable iff (!reset)
        grant_scaler |-> !scaler_busy)
    else
    begin
        $error("scaler granted without a credit");
        fail_count++;
    end

    a_wheel_credit: assert property (@(posedge clk) disable iff (!reset)
        grant_wheel |-> !wheel_busy)
    else
    begin
        $error("wheel granted without a credit");
        fail_count++;
    end

    a_off_pins_low: assert property (@(posedge clk) disable iff (!reset)
        (off_cycles >= OFF_SETTLE) |-> !(pin_r || pin_g || pin_b || pin_w))
    else
    begin
        $error("pwm pin high while mode is off");
        fail_count++;
    end

endmodule

bind rgbw_controller rgbw_chk chk_i (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .grant_scaler (grant_scaler),
    .grant_wheel  (grant_wheel),
    .valid_scaler (valid_scaler),
    .valid_wheel  (valid_wheel),
    .pin_r        (pin_r),
    .pin_g        (pin_g),
    .pin_b        (pin_b),
    .pin_w        (pin_w)
);

//--- tests/tb_rgbw_controller.sv
`timescale 1ns/10ps
`include "led_macros.svh"

module tb_rgbw_controller
    import led_cfg_pkg::*;
();

    localparam int PWM_PERIOD    = 256 * `PWM_PRESCALE;
    localparam int SPI_HALF      = 4;
    localparam int RESET_TIMEOUT = 100;

    logic clk;
    logic reset;
    logic sck;
    logic cs;
    logic mosi;
    logic pin_r;
    logic pin_g;
    logic pin_b;
    logic pin_w;

    int seed = 90;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_before;
    int cnt_r;
    int cnt_g;
    int cnt_b;
    int cnt_w;
    int v_red;
    int v_green;
    int v_blue;
    int v_white;
    int lvl;
    int raw_r;
    int raw_g;
    int raw_b;
    bit reset_seen;
    int hues [4] = '{0, 42, 100, 200};

    clock_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    rgbw_controller dut_i (
        .clk   (clk),
        .reset (reset),
        .sck   (sck),
        .cs    (cs),
        .mosi  (mosi),
        .pin_r (pin_r),
        .pin_g (pin_g),
        .pin_b (pin_b),
        .pin_w (pin_w)
    );

    // upper byte of an 8x8 product
    function automatic int upper_byte(input int v, input int l);
        return (v * l) >> 8;
    endfunction

    // raw colour for a hue position, per sector
    task automatic hue_color(input int i, output int r, output int g, output int b);
        int j;
        begin
            if (i < `HUE_SECTOR)
            begin
                r = 255 - 3 * i;
                g = 3 * i;
                b = 0;
            end
            else if (i < 2 * `HUE_SECTOR)
            begin
                j = i - `HUE_SECTOR;
                r = 0;
                g = 255 - 3 * j;
                b = 3 * j;
            end
            else
            begin
                j = i - 2 * `HUE_SECTOR;
                r = 3 * j;
                g = 0;
                b = 255 - 3 * j;
            end
        end
    endtask

    // mode 0, msb first, cs raised after nbits
    task automatic spi_send(input logic [15:0] word, input int nbits);
        int i;
        begin
            @(negedge clk);
            cs = 1'b0;
            repeat (SPI_HALF) @(negedge clk);
            for (i = 15; i > 15 - nbits; i--)
            begin
                mosi = word[i];
                repeat (SPI_HALF) @(negedge clk);
                sck = 1'b1;
                repeat (SPI_HALF) @(negedge clk);
                sck = 1'b0;
            end
            repeat (SPI_HALF) @(negedge clk);
            cs = 1'b1;
            repeat (2 * SPI_HALF) @(negedge clk);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        spi_send({addr, data}, 16);
    endtask

    task automatic wait_reset_release(output bit seen);
        int waited;
        begin
            waited = 0;
            while (reset !== 1'b1 && waited < RESET_TIMEOUT)
            begin
                @(negedge clk);
                waited++;
            end
            seen = (reset === 1'b1);
        end
    endtask

    // count high cycles per pin over one pwm period
    task automatic measure_pins();
        cnt_r = 0;
        cnt_g = 0;
        cnt_b = 0;
        cnt_w = 0;
        repeat (PWM_PERIOD)
        begin
            @(negedge clk);
            cnt_r += pin_r;
            cnt_g += pin_g;
            cnt_b += pin_b;
            cnt_w += pin_w;
        end
    endtask

    task automatic check_pin(input string name, input int got, input int want);
        assert (got == want)
        else
        begin
            $display("Fail at %0t ns: %s high for %0d cycles, expected %0d",
                     $time, name, got, want);
            errors++;
        end
    endtask

    // duties are 0..255, each counter step lasts PWM_PRESCALE cycles
    task automatic check_duties(input int dr, input int dg, input int db, input int dw);
        measure_pins();
        check_pin("pin_r", cnt_r, `PWM_PRESCALE * dr);
        check_pin("pin_g", cnt_g, `PWM_PRESCALE * dg);
        check_pin("pin_b", cnt_b, `PWM_PRESCALE * db);
        check_pin("pin_w", cnt_w, `PWM_PRESCALE * dw);
    endtask

    // new duties latch at a wrap, two periods cover the worst case
    task automatic settle();
        repeat (2 * PWM_PERIOD) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > err_before)
        begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
        else
        begin
            $display("test %0d %s: ok", tests_run, name);
        end
        err_before = errors;
    endtask

    initial
    begin
        sck = 1'b0;
        cs = 1'b1;
        mosi = 1'b0;
        err_before = 0;
        wait_reset_release(reset_seen);
        if (!reset_seen)
        begin
            $display("Reset was never released within the timeout.");
            $display("RESULT: FAIL");
        end
        else
        begin
            check_duties(0, 0, 0, 0);
            finish_test("reset pins low");

            v_red = $random(seed) & 8'hff;
            v_green = $random(seed) & 8'hff;
            v_blue = $random(seed) & 8'hff;
            v_white = $random(seed) & 8'hff;
            write_reg(ADDR_LINT, 8'd255);
            write_reg(ADDR_RED, v_red);
            write_reg(ADDR_GREEN, v_green);
            write_reg(ADDR_BLUE, v_blue);
            write_reg(ADDR_WHITE, v_white);
            write_reg(ADDR_MODE, MODE_STATIC);
            settle();
            check_duties(upper_byte(v_red, 255), upper_byte(v_green, 255),
                         upper_byte(v_blue, 255), upper_byte(v_white, 255));
            finish_test("static full intensity");

            lvl = $random(seed) & 8'hff;
            write_reg(ADDR_LINT, lvl);
            settle();
            check_duties(upper_byte(v_red, lvl), upper_byte(v_green, lvl),
                         upper_byte(v_blue, lvl), upper_byte(v_white, lvl));
            finish_test("static random intensity");

            write_reg(ADDR_LINT, 8'd255);
            write_reg(ADDR_MODE, MODE_WHEEL);
            foreach (hues[k])
            begin
                write_reg(ADDR_HUE, hues[k]);
                settle();
                hue_color(hues[k], raw_r, raw_g, raw_b);
                check_duties(upper_byte(raw_r, 255), upper_byte(raw_g, 255),
                             upper_byte(raw_b, 255), upper_byte(v_white, 255));
            end
            finish_test("hue wheel sectors");

            // a leaked partial byte would turn the hue address into mode data
            write_reg(8'd9, $random(seed) & 8'h7f);
            spi_send({ADDR_MODE, 8'h00}, 8);
            write_reg(ADDR_HUE, hues[3]);
            settle();
            check_duties(upper_byte(raw_r, 255), upper_byte(raw_g, 255),
                         upper_byte(raw_b, 255), upper_byte(v_white, 255));
            finish_test("bad address and aborted transfer");

            write_reg(ADDR_MODE, MODE_OFF);
            settle();
            check_duties(0, 0, 0, 0);
            finish_test("mode off");

            $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                     tests_run, tests_failed, errors, dut_i.chk_i.fail_count);
            if (errors == 0 && dut_i.chk_i.fail_count == 0)
                $display("RESULT: PASS");
            else
                $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
